// ==== rtl/ring_pkg.sv ====
// ring node shared definitions
// packet word layout, payload views, packet kinds and node id width
// a ring word is one packet per cycle, valid bit first

package ring_pkg;

	// ==================================================
	// node id and packet kinds
	// ==================================================

	localparam int NODE_ID_W = 6;

	typedef enum logic [1:0] {
		PKT_EMPTY = 2'd0,
		PKT_WRITE = 2'd1,
		PKT_READ  = 2'd2,
		PKT_RESP  = 2'd3
	} pkt_kind_e;

	// response status codes
	localparam logic [7:0] RSP_OK      = 8'd0;
	localparam logic [7:0] RSP_BAD_ADR = 8'd1;

	// ==================================================
	// payload views
	// ==================================================

	// request view, byte address and write byte
	typedef struct packed {
		logic [15:0] adr;
		logic [7:0]  dat;
	} req_payload_t;

	// response view, status then low address echo then read byte
	typedef struct packed {
		logic [7:0] status;
		logic [7:0] adr_lo;
		logic [7:0] dat;
	} rsp_payload_t;

	// same 24 bits, decoded by kind
	typedef union packed {
		req_payload_t req;
		rsp_payload_t rsp;
	} payload_u;

	// 39 bit ring word
	typedef struct packed {
		logic                 valid;
		pkt_kind_e            kind;
		logic [NODE_ID_W-1:0] dst;
		logic [NODE_ID_W-1:0] src;
		payload_u             payload;
	} packet_t;

endpackage

// ==== rtl/node_ram.sv ====
// node local byte RAM
// single port, registered read, write-first
// read data is valid one clock after the access

`timescale 1ns/1ps

module node_ram #(
	parameter int RAM_ADR_W = 10
) (
	input  logic                 clk_i,
	input  logic                 en_i,
	input  logic                 we_i,
	input  logic [RAM_ADR_W-1:0] adr_i,
	input  logic [7:0]           dat_i,
	output logic [7:0]           dat_o
);

	localparam int DEPTH = 1 << RAM_ADR_W;

	// storage, contents are undefined after power up
	logic [7:0] mem [DEPTH];

	// read data register
	logic [7:0] dat_q;

	always_ff @(posedge clk_i) begin
		if (en_i) begin
			if (we_i) begin
				mem[adr_i] <= dat_i;
				// write-first, new byte shows on the output
				dat_q <= dat_i;
			end else begin
				dat_q <= mem[adr_i];
			end
		end
	end

	assign dat_o = dat_q;

	// a write strobe only comes as part of an enabled access
	a_we_needs_en: assert property (
		@(posedge clk_i) we_i |-> en_i
	);

endmodule

// ==== rtl/ring_rx_stage.sv ====
// ring receive and decode stage
// registers the incoming ring word, decodes it against the node id
// and issues the local RAM access for requests addressed here

`timescale 1ns/1ps

module ring_rx_stage import ring_pkg::*; #(
	parameter int RAM_ADR_W = 10
) (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic [NODE_ID_W-1:0] id_i,
	input  packet_t              packet_i,
	output packet_t              packet_o,
	output logic                 hit_req_o,
	output logic                 hit_rsp_o,
	output logic                 range_ok_o,
	output logic                 ram_en_o,
	output logic                 ram_we_o,
	output logic [RAM_ADR_W-1:0] ram_adr_o,
	output logic [7:0]           ram_dat_o
);

	packet_t pkt_q;
	logic    for_me;
	logic    is_wr;
	logic    is_rd;

	// ==================================================
	// input register
	// ==================================================

	// only the valid bit needs clearing
	always_ff @(posedge clk_i) begin
		pkt_q <= packet_i;
		if (rst_i) begin
			pkt_q.valid <= 1'b0;
		end
	end

	assign packet_o = pkt_q;

	// ==================================================
	// decode
	// ==================================================

	assign for_me = pkt_q.valid && (pkt_q.dst == id_i);
	assign is_wr  = (pkt_q.kind == PKT_WRITE);
	assign is_rd  = (pkt_q.kind == PKT_READ);

	assign hit_req_o = for_me && (is_wr || is_rd);
	assign hit_rsp_o = for_me && (pkt_q.kind == PKT_RESP);

	// address must fit in the RAM, upper bits all zero
	assign range_ok_o = ((pkt_q.payload.req.adr >> RAM_ADR_W) == 16'd0);

	// RAM port, word sits here for one cycle so a write lands once
	assign ram_en_o  = hit_req_o;
	assign ram_we_o  = hit_req_o && is_wr && range_ok_o;
	assign ram_adr_o = pkt_q.payload.req.adr[RAM_ADR_W-1:0];
	assign ram_dat_o = pkt_q.payload.req.dat;

endmodule

// ==== rtl/mem_access_stage.sv ====
// ring memory access stage
// rewrites requests for this node into responses, consumes responses
// for this node and strobes them to the host, forwards everything else
// the RAM read byte arrives with this stage's register and is merged
// on the output

`timescale 1ns/1ps

module mem_access_stage import ring_pkg::*; (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic [NODE_ID_W-1:0] id_i,
	input  packet_t              packet_i,
	input  logic                 hit_req_i,
	input  logic                 hit_rsp_i,
	input  logic                 range_ok_i,
	input  logic [7:0]           ram_dat_i,
	output packet_t              packet_o,
	output logic                 rsp_valid_o,
	output logic [NODE_ID_W-1:0] rsp_src_o,
	output logic [7:0]           rsp_status_o,
	output logic [7:0]           rsp_adr_o,
	output logic [7:0]           rsp_dat_o
);

	packet_t pkt_nxt;
	packet_t pkt_q;
	logic    is_wr;
	logic    is_rd;
	logic    use_ram_d;
	logic    use_ram_q;
	logic    rsp_valid_q;
	logic [NODE_ID_W-1:0] rsp_src_q;
	logic [7:0] rsp_status_q;
	logic [7:0] rsp_adr_q;
	logic [7:0] rsp_dat_q;

	assign is_wr = (packet_i.kind == PKT_WRITE);
	assign is_rd = (packet_i.kind == PKT_READ);

	// good read takes its data byte from the RAM one cycle later
	assign use_ram_d = hit_req_i && is_rd && range_ok_i;

	// ==================================================
	// next word
	// ==================================================

	always_comb begin
		// forward unchanged by default
		pkt_nxt = packet_i;
		if (hit_req_i) begin
			pkt_nxt.kind = PKT_RESP;
			// reply goes back to the requester
			pkt_nxt.dst  = packet_i.src;
			pkt_nxt.src  = id_i;
			pkt_nxt.payload.rsp.status = range_ok_i ? RSP_OK : RSP_BAD_ADR;
			pkt_nxt.payload.rsp.adr_lo = packet_i.payload.req.adr[7:0];
			// written byte on a good write, zero on error
			// read byte is filled in on the output
			if (is_wr && range_ok_i) begin
				pkt_nxt.payload.rsp.dat = packet_i.payload.req.dat;
			end else begin
				pkt_nxt.payload.rsp.dat = 8'h00;
			end
		end else if (hit_rsp_i) begin
			// consumed here, slot goes out empty
			pkt_nxt = '0;
		end
	end

	// ==================================================
	// stage register
	// ==================================================

	always_ff @(posedge clk_i) begin
		pkt_q <= pkt_nxt;
		if (rst_i) begin
			pkt_q.valid <= 1'b0;
			use_ram_q   <= 1'b0;
			rsp_valid_q <= 1'b0;
		end else begin
			use_ram_q   <= use_ram_d;
			rsp_valid_q <= hit_rsp_i;
		end
	end

	// host response fields, qualified by rsp_valid_q
	always_ff @(posedge clk_i) begin
		rsp_src_q    <= packet_i.src;
		rsp_status_q <= packet_i.payload.rsp.status;
		rsp_adr_q    <= packet_i.payload.rsp.adr_lo;
		rsp_dat_q    <= packet_i.payload.rsp.dat;
	end

	// merge RAM read byte into the registered response
	always_comb begin
		packet_o = pkt_q;
		if (use_ram_q) begin
			packet_o.payload.rsp.dat = ram_dat_i;
		end
	end

	assign rsp_valid_o  = rsp_valid_q;
	assign rsp_src_o    = rsp_src_q;
	assign rsp_status_o = rsp_status_q;
	assign rsp_adr_o    = rsp_adr_q;
	assign rsp_dat_o    = rsp_dat_q;

	// decode from stage 1 is one-hot and only for live words
	a_hit_onehot: assert property (
		@(posedge clk_i) disable iff (rst_i)
		!(hit_req_i && hit_rsp_i)
	);

	a_hit_valid: assert property (
		@(posedge clk_i) disable iff (rst_i)
		(hit_req_i || hit_rsp_i) |-> packet_i.valid
	);

endmodule

// ==== rtl/ring_tx_stage.sv ====
// ring transmit and merge stage
// holds one host request and drops it into the first empty slot
// passing through, then registers the ring output word

`timescale 1ns/1ps

module ring_tx_stage import ring_pkg::*; (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic [NODE_ID_W-1:0] id_i,
	input  packet_t              packet_i,
	input  logic                 inj_valid_i,
	input  pkt_kind_e            inj_kind_i,
	input  logic [NODE_ID_W-1:0] inj_dst_i,
	input  logic [15:0]          inj_adr_i,
	input  logic [7:0]           inj_dat_i,
	output packet_t              packet_o,
	output logic                 inj_busy_o
);

	// injection buffer
	logic                 buf_full_q;
	pkt_kind_e            buf_kind_q;
	logic [NODE_ID_W-1:0] buf_dst_q;
	logic [15:0]          buf_adr_q;
	logic [7:0]           buf_dat_q;

	packet_t inj_pkt;
	packet_t out_q;
	logic    take;
	logic    load;

	// ==================================================
	// buffer control
	// ==================================================

	// strobes while full are dropped
	assign load = inj_valid_i && !buf_full_q;
	// slot is free when stage 2 hands us an invalid word
	assign take = buf_full_q && !packet_i.valid;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			buf_full_q <= 1'b0;
		end else if (load) begin
			buf_full_q <= 1'b1;
		end else if (take) begin
			buf_full_q <= 1'b0;
		end
	end

	// request fields, no reset
	always_ff @(posedge clk_i) begin
		if (load) begin
			buf_kind_q <= inj_kind_i;
			buf_dst_q  <= inj_dst_i;
			buf_adr_q  <= inj_adr_i;
			buf_dat_q  <= inj_dat_i;
		end
	end

	// ==================================================
	// output merge
	// ==================================================

	always_comb begin
		inj_pkt.valid           = 1'b1;
		inj_pkt.kind            = buf_kind_q;
		inj_pkt.dst             = buf_dst_q;
		inj_pkt.src             = id_i;
		inj_pkt.payload.req.adr = buf_adr_q;
		inj_pkt.payload.req.dat = buf_dat_q;
	end

	always_ff @(posedge clk_i) begin
		out_q <= take ? inj_pkt : packet_i;
		if (rst_i) begin
			out_q.valid <= 1'b0;
		end
	end

	assign packet_o   = out_q;
	assign inj_busy_o = buf_full_q;

	// host must wait for busy to drop before the next strobe
	a_no_strobe_busy: assert property (
		@(posedge clk_i) disable iff (rst_i)
		inj_valid_i |-> !inj_busy_o
	);

endmodule

// ==== rtl/ring_node.sv ====
// ring network processing node
// three stage pipeline, receive/decode then memory access then
// transmit/merge, with a local byte RAM serving remote requests
// and a one-entry host injection buffer

`timescale 1ns/1ps

module ring_node import ring_pkg::*; #(
	parameter int RAM_ADR_W = 10
) (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic [NODE_ID_W-1:0] id_i,
	input  packet_t              packet_i,
	output packet_t              packet_o,
	input  logic                 inj_valid_i,
	input  pkt_kind_e            inj_kind_i,
	input  logic [NODE_ID_W-1:0] inj_dst_i,
	input  logic [15:0]          inj_adr_i,
	input  logic [7:0]           inj_dat_i,
	output logic                 inj_busy_o,
	output logic                 rsp_valid_o,
	output logic [NODE_ID_W-1:0] rsp_src_o,
	output logic [7:0]           rsp_status_o,
	output logic [7:0]           rsp_adr_o,
	output logic [7:0]           rsp_dat_o
);

	// stage 1 to stage 2
	packet_t rx_pkt;
	logic    hit_req;
	logic    hit_rsp;
	logic    range_ok;

	// RAM port
	logic                 ram_en;
	logic                 ram_we;
	logic [RAM_ADR_W-1:0] ram_adr;
	logic [7:0]           ram_wdat;
	logic [7:0]           ram_rdat;

	// stage 2 to stage 3
	packet_t ma_pkt;

	// ==================================================
	// stage 1
	// ==================================================

	ring_rx_stage #(
		.RAM_ADR_W(RAM_ADR_W)
	) u_rx (
		.clk_i, .rst_i, .id_i, .packet_i,
		.packet_o(rx_pkt),
		.hit_req_o(hit_req),
		.hit_rsp_o(hit_rsp),
		.range_ok_o(range_ok),
		.ram_en_o(ram_en),
		.ram_we_o(ram_we),
		.ram_adr_o(ram_adr),
		.ram_dat_o(ram_wdat)
	);

	node_ram #(
		.RAM_ADR_W(RAM_ADR_W)
	) u_ram (
		.clk_i,
		.en_i(ram_en),
		.we_i(ram_we),
		.adr_i(ram_adr),
		.dat_i(ram_wdat),
		.dat_o(ram_rdat)
	);

	// ==================================================
	// stages 2 and 3
	// ==================================================

	mem_access_stage u_mem (
		.clk_i, .rst_i, .id_i,
		.packet_i(rx_pkt),
		.hit_req_i(hit_req),
		.hit_rsp_i(hit_rsp),
		.range_ok_i(range_ok),
		.ram_dat_i(ram_rdat),
		.packet_o(ma_pkt),
		.rsp_valid_o, .rsp_src_o, .rsp_status_o, .rsp_adr_o, .rsp_dat_o
	);

	ring_tx_stage u_tx (
		.clk_i, .rst_i, .id_i,
		.packet_i(ma_pkt),
		.inj_valid_i, .inj_kind_i, .inj_dst_i, .inj_adr_i, .inj_dat_i,
		.packet_o,
		.inj_busy_o
	);

endmodule

// ==== bench/tb_ring_ref.svh ====
// ring node reference model
// shadow copy of the node RAM, expected ring word for every word sent
// and packet build and print helpers
// included in the testbench top after RAM_ADR_W and NODE_ID

`ifndef TB_RING_REF_SVH
`define TB_RING_REF_SVH

// shadow of the node RAM, follows every good write
logic [7:0] shadow_mem [1 << RAM_ADR_W];

// expected output word for one input word
// host_v is set when the word is a response that the host receives
function automatic packet_t expect_packet(
	input  packet_t p,
	output logic    host_v
);
	packet_t     e;
	logic [15:0] adr;
	logic [7:0]  wdat;
	logic        in_range;
	e        = p;
	host_v   = 1'b0;
	// read the request view before the response view is written
	adr      = p.payload.req.adr;
	wdat     = p.payload.req.dat;
	in_range = int'(adr) < (1 << RAM_ADR_W);
	if (p.valid && (p.dst == NODE_ID)) begin
		if ((p.kind == PKT_WRITE) || (p.kind == PKT_READ)) begin
			// reply to the requester in the same slot
			e.kind               = PKT_RESP;
			e.dst                = p.src;
			e.src                = NODE_ID;
			e.payload.rsp.status = in_range ? 8'd0 : 8'd1;
			e.payload.rsp.adr_lo = adr[7:0];
			e.payload.rsp.dat    = 8'd0;
			if (in_range && (p.kind == PKT_WRITE)) begin
				shadow_mem[adr[RAM_ADR_W-1:0]] = wdat;
				e.payload.rsp.dat = wdat;
			end else if (in_range) begin
				e.payload.rsp.dat = shadow_mem[adr[RAM_ADR_W-1:0]];
			end
		end else if (p.kind == PKT_RESP) begin
			// host takes it, slot leaves empty
			host_v = 1'b1;
			e      = '0;
		end
	end
	return e;
endfunction

function automatic packet_t make_pkt(
	input logic                 v,
	input pkt_kind_e            k,
	input logic [NODE_ID_W-1:0] dst,
	input logic [NODE_ID_W-1:0] src,
	input logic [23:0]          pl
);
	packet_t p;
	p.valid   = v;
	p.kind    = k;
	p.dst     = dst;
	p.src     = src;
	p.payload = pl;
	return p;
endfunction

function automatic string pkt_str(input packet_t p);
	return $sformatf("{v=%0d k=%0d dst=%0d src=%0d pl=%06h}",
		p.valid, p.kind, p.dst, p.src, p.payload);
endfunction

`endif

// ==== bench/tb_ring_node.sv ====
// testbench for the ring network node
// drives one ring word per cycle and plays the host port
// a compare process checks the ring output, the host response port
// and the injection busy flag against the reference model

`timescale 1ns/1ps

module tb_ring_node import ring_pkg::*; ();

	localparam int RAM_ADR_W = 10;
	localparam logic [NODE_ID_W-1:0] NODE_ID = 6'd5;
	localparam logic [31:0] SEED = 32'ha3ea_31f1;

	localparam int N_FWD  = 200;
	localparam int N_WR   = 16;
	localparam int N_OOR  = 4;
	localparam int N_RSP  = 8;
	localparam int N_FULL = 20;

	// every driven cycle, reset and drain included
	localparam int STIM_CYCLES = 10 + 5 + N_FWD + 2 * N_WR + 4 + 3 * N_OOR
		+ 2 * N_RSP + N_FULL + 12 + 1 + 12 + 2;
	localparam int MAX_CYCLES = 2 * STIM_CYCLES + 100;

	logic                 clk_i;
	logic                 rst_i;
	logic [NODE_ID_W-1:0] id_i;
	packet_t              packet_i;
	packet_t              packet_o;
	logic                 inj_valid_i;
	pkt_kind_e            inj_kind_i;
	logic [NODE_ID_W-1:0] inj_dst_i;
	logic [15:0]          inj_adr_i;
	logic [7:0]           inj_dat_i;
	logic                 inj_busy_o;
	logic                 rsp_valid_o;
	logic [NODE_ID_W-1:0] rsp_src_o;
	logic [7:0]           rsp_status_o;
	logic [7:0]           rsp_adr_o;
	logic [7:0]           rsp_dat_o;

	// expectations with the negedge count at which they are due
	int      ring_due_q [$];
	packet_t ring_exp_q [$];
	int      host_due_q [$];
	packet_t host_exp_q [$];

	int          val_errors;
	int          other_errors;
	logic        inj_pending;
	int          inj_from;
	packet_t     inj_exp;
	logic [15:0] wr_adr [N_WR];

	`include "tb_ring_ref.svh"

	ring_node #(
		.RAM_ADR_W(RAM_ADR_W)
	) u_dut (
		.clk_i, .rst_i, .id_i, .packet_i, .packet_o,
		.inj_valid_i, .inj_kind_i, .inj_dst_i, .inj_adr_i, .inj_dat_i,
		.inj_busy_o,
		.rsp_valid_o, .rsp_src_o, .rsp_status_o, .rsp_adr_o, .rsp_dat_o
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	// watchdog
	initial begin
		int n;
		n = 0;
		while (n < MAX_CYCLES) begin
			@(posedge clk_i);
			n++;
		end
		$display("timeout, run did not end within %0d cycles", MAX_CYCLES);
		$display("TB FAILED");
		$finish;
	end

	task automatic check_pkt(input string name, input packet_t got, input packet_t exp);
		if (got !== exp) begin
			$display("FAILED %0t %s got %s expected %s", $time, name,
				pkt_str(got), pkt_str(exp));
			val_errors++;
		end
	endtask

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %0t %s got %0h expected %0h", $time, name, got, exp);
			val_errors++;
		end
	endtask

	// ==================================================
	// compare process, runs on the falling edge
	// ==================================================

	initial begin
		int      cyc;
		logic    exp_v;
		logic    host_v;
		packet_t exp_pkt;
		packet_t host_exp;
		cyc = 0;
		val_errors  = 0;
		inj_pending = 1'b0;
		inj_from    = 0;
		forever begin
			@(negedge clk_i);
			cyc++;
			exp_v  = 1'b0;
			host_v = 1'b0;
			exp_pkt = '0;
			host_exp = '0;
			if ((ring_due_q.size() > 0) && (ring_due_q[0] == cyc)) begin
				void'(ring_due_q.pop_front());
				exp_pkt = ring_exp_q.pop_front();
				exp_v   = 1'b1;
			end
			if ((host_due_q.size() > 0) && (host_due_q[0] == cyc)) begin
				void'(host_due_q.pop_front());
				host_exp = host_exp_q.pop_front();
				host_v   = 1'b1;
			end
			if (rst_i) begin
				check_val("packet_o.valid", 32'(packet_o.valid), 32'd0);
				check_val("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
				check_val("inj_busy_o", 32'(inj_busy_o), 32'd0);
			end else begin
				// buffered request takes the first empty slot it may use
				if (inj_pending && (cyc >= inj_from) && exp_v && !exp_pkt.valid) begin
					exp_pkt     = inj_exp;
					inj_pending = 1'b0;
				end
				if (exp_v) begin
					check_pkt("packet_o", packet_o, exp_pkt);
				end
				check_val("rsp_valid_o", 32'(rsp_valid_o), 32'(host_v));
				if (host_v) begin
					check_val("rsp_src_o", 32'(rsp_src_o), 32'(host_exp.src));
					check_val("rsp_status_o", 32'(rsp_status_o),
						32'(host_exp.payload.rsp.status));
					check_val("rsp_adr_o", 32'(rsp_adr_o), 32'(host_exp.payload.rsp.adr_lo));
					check_val("rsp_dat_o", 32'(rsp_dat_o), 32'(host_exp.payload.rsp.dat));
				end
				check_val("inj_busy_o", 32'(inj_busy_o), 32'(inj_pending));
				if (inj_valid_i) begin
					// loads on the next edge, may leave one edge after that
					inj_exp = make_pkt(1'b1, inj_kind_i, inj_dst_i, NODE_ID,
						{inj_adr_i, inj_dat_i});
					inj_from    = cyc + 2;
					inj_pending = 1'b1;
				end
			end
			exp_pkt = expect_packet(packet_i, host_v);
			ring_due_q.push_back(cyc + 3);
			ring_exp_q.push_back(exp_pkt);
			if (host_v) begin
				host_due_q.push_back(cyc + 2);
				host_exp_q.push_back(packet_i);
			end
		end
	end

	// ==================================================
	// stimulus
	// ==================================================

	task automatic send_word(input packet_t p);
		@(posedge clk_i);
		packet_i    <= p;
		inj_valid_i <= 1'b0;
	endtask

	task automatic send_idle(input int n);
		repeat (n) send_word('0);
	endtask

	task automatic send_with_inj(input packet_t p, input pkt_kind_e kind,
		input logic [NODE_ID_W-1:0] dst, input logic [15:0] adr, input logic [7:0] dat);
		@(posedge clk_i);
		packet_i    <= p;
		inj_valid_i <= 1'b1;
		inj_kind_i  <= kind;
		inj_dst_i   <= dst;
		inj_adr_i   <= adr;
		inj_dat_i   <= dat;
	endtask

	initial begin
		packet_t     p;
		logic [31:0] r;
		logic [31:0] r2;
		logic [15:0] adr;
		other_errors = 0;
		r = $urandom(SEED);
		rst_i       = 1'b1;
		id_i        = NODE_ID;
		packet_i    = '0;
		inj_valid_i = 1'b0;
		inj_kind_i  = PKT_EMPTY;
		inj_dst_i   = '0;
		inj_adr_i   = '0;
		inj_dat_i   = '0;
		repeat (10) @(posedge clk_i);
		rst_i <= 1'b0;
		send_idle(5);

		// random traffic for other nodes, empty words mixed in
		for (int i = 0; i < N_FWD; i++) begin
			r  = $urandom;
			r2 = $urandom;
			p = make_pkt(r[0], pkt_kind_e'(r[2:1]), r[8:3], r[14:9], r2[23:0]);
			if (p.dst == NODE_ID) begin
				p.dst = NODE_ID + 6'd1;
			end
			send_word(p);
		end

		// writes to this node, then reads of the same addresses
		for (int i = 0; i < N_WR; i++) begin
			r = $urandom;
			wr_adr[i] = {6'd0, r[9:0]};
			send_word(make_pkt(1'b1, PKT_WRITE, NODE_ID, r[15:10], {wr_adr[i], r[23:16]}));
		end
		send_idle(4);
		for (int i = 0; i < N_WR; i++) begin
			r = $urandom;
			send_word(make_pkt(1'b1, PKT_READ, NODE_ID, r[5:0], {wr_adr[i], r[13:6]}));
		end

		// out of range write and read, then the aliased low address
		for (int i = 0; i < N_OOR; i++) begin
			r = $urandom;
			adr = wr_adr[i] | (16'h0400 << i);
			send_word(make_pkt(1'b1, PKT_WRITE, NODE_ID, r[5:0], {adr, r[15:8]}));
		end
		for (int i = 0; i < N_OOR; i++) begin
			adr = wr_adr[i] | (16'h0400 << i);
			send_word(make_pkt(1'b1, PKT_READ, NODE_ID, 6'd3, {adr, 8'h00}));
		end
		for (int i = 0; i < N_OOR; i++) begin
			send_word(make_pkt(1'b1, PKT_READ, NODE_ID, 6'd4, {wr_adr[i], 8'h00}));
		end

		// responses for this node, each followed by one for node 7
		for (int i = 0; i < N_RSP; i++) begin
			r  = $urandom;
			r2 = $urandom;
			send_word(make_pkt(1'b1, PKT_RESP, NODE_ID, r[5:0], r2[23:0]));
			send_word(make_pkt(1'b1, PKT_RESP, 6'd7, r[11:6], r2[31:8]));
		end

		// injection into a full ring waits for the first empty slot
		r = $urandom;
		send_with_inj(make_pkt(1'b1, PKT_READ, 6'd9, 6'd2, r[23:0]),
			PKT_WRITE, 6'd12, 16'h0123, r[31:24]);
		for (int i = 1; i < N_FULL; i++) begin
			r = $urandom;
			send_word(make_pkt(1'b1, PKT_WRITE, 6'd9, r[5:0], r[29:6]));
		end
		send_idle(12);

		// injection into an idle ring
		send_with_inj('0, PKT_READ, 6'd9, 16'h0044, 8'h00);
		send_idle(12);

		@(negedge clk_i);
		if (inj_busy_o) begin
			$display("injection buffer still full at the end of the run");
			other_errors++;
		end
		// last falling edge compare is done by the next rising edge
		@(posedge clk_i);
		$display("run done, %0d value errors, %0d other errors", val_errors, other_errors);
		if ((val_errors == 0) && (other_errors == 0)) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+bench
rtl/ring_pkg.sv
rtl/node_ram.sv
rtl/ring_rx_stage.sv
rtl/mem_access_stage.sv
rtl/ring_tx_stage.sv
rtl/ring_node.sv
bench/tb_ring_node.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the ring node testbench with Verilator and runs it
# the run counts as passed only if the log holds the pass line

set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --assert --timing -j 0 \
	-f flist.f \
	--top-module tb_ring_node \
	-o tb_ring_node_sim

./obj_dir/tb_ring_node_sim | tee sim.log

if grep -qx "TB PASSED" sim.log; then
	echo "simulation ok"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
